// File: sources.f
+incdir+src
src/icache_pkg.sv
src/icache_fill_if.sv
src/icache_array.sv
src/icache_refill_ctrl.sv
src/icache_perf.sv
src/icache_top.sv
verification/icache_tb.sv

// File: src/icache_array.sv
`timescale 1ns/10ps
`include "icache_params.svh"

module icache_array (
    input  logic              clk_i,
    input  logic              rst_ni,

    // Lookup side
    input  icache_pkg::addr_t lookup_addr_i,
    input  logic              touch_i,
    input  logic              flush_i,

    // Line refill writes
    icache_fill_if.array      fill,

    // Lookup results
    output logic              hit_o,
    output logic              hit_way_o,
    output logic              victim_way_o,
    output icache_pkg::word_t hit_data_o
);

    // =================================================================
    // Storage
    // =================================================================

    // Valid bits per way, one per set
    logic [`ICACHE_SETS-1:0] valid_q [`ICACHE_WAYS];

    // LRU bit per set holds the most recently used way
    logic [`ICACHE_SETS-1:0] lru_q;

    // Tag and data arrays
    icache_pkg::tag_t  tag_q  [`ICACHE_WAYS][`ICACHE_SETS];
    icache_pkg::word_t data_q [`ICACHE_WAYS][`ICACHE_SETS][`ICACHE_LINE_WORDS];

    // Lookup address fields
    icache_pkg::tag_t      lk_tag;
    icache_pkg::index_t    lk_index;
    icache_pkg::word_sel_t lk_wsel;

    logic [`ICACHE_WAYS-1:0] way_hit;

    // =================================================================
    // Lookup
    // =================================================================

    // Drop the byte offset, the rest splits into tag, index, word
    assign {lk_tag, lk_index, lk_wsel} = lookup_addr_i[`ICACHE_ADDR_W-1:2];

    // Compare both ways in parallel
    always_comb begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            way_hit[w] = valid_q[w][lk_index] && (tag_q[w][lk_index] == lk_tag);
        end
    end

    assign hit_o      = |way_hit;
    assign hit_way_o  = way_hit[1];
    assign hit_data_o = data_q[hit_way_o][lk_index][lk_wsel];

    // Replace whichever way was not used last
    assign victim_way_o = ~lru_q[lk_index];

    // =================================================================
    // Valid and LRU state
    // =================================================================

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                valid_q[w] <= '0;
            end
            lru_q <= '0;
        end else if (flush_i) begin
            // Flush drops every line at once
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                valid_q[w] <= '0;
            end
            lru_q <= '0;
        end else if (fill.commit) begin
            valid_q[fill.way][fill.index] <= 1'b1;
            lru_q[fill.index]             <= fill.way;
        end else if (touch_i) begin
            // Hit makes the hit way most recent
            lru_q[lk_index] <= hit_way_o;
        end
    end

    // Line payload, written word by word during refill
    always_ff @(posedge clk_i) begin
        if (fill.word_we) begin
            data_q[fill.way][fill.index][fill.word_sel] <= fill.data;
        end
        if (fill.commit) begin
            tag_q[fill.way][fill.index] <= fill.tag;
        end
    end

    // A line is only ever filled into one way, so both cannot match
    a_single_way_hit : assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(way_hit));

endmodule

// File: src/icache_fill_if.sv
`timescale 1ns/10ps

interface icache_fill_if;

    // One data word written per memory response
    logic                  word_we;
    logic                  way;
    icache_pkg::index_t    index;
    icache_pkg::word_sel_t word_sel;
    icache_pkg::word_t     data;

    // Last word of the line, set valid, tag and LRU
    logic                  commit;
    icache_pkg::tag_t      tag;

    // Refill controller drives the fill
    modport ctrl (
        output word_we, way, index, word_sel, data, commit, tag
    );

    // Array receives it
    modport array (
        input word_we, way, index, word_sel, data, commit, tag
    );

endinterface

// File: src/icache_params.svh
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// =====================================================================
// Instruction cache geometry
// =====================================================================

// Byte address width of the fetch path
`define ICACHE_ADDR_W 32

// Words per line, four 32-bit words give a 16-byte line
`define ICACHE_LINE_WORDS 4

// Number of sets
`define ICACHE_SETS 8

// Associativity, the single LRU bit per set only covers two
`define ICACHE_WAYS 2

`endif

// File: src/icache_perf.sv
`timescale 1ns/10ps

module icache_perf (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        access_i,
    input  logic        access_hit_i,
    output logic [31:0] hit_count_o,
    output logic [31:0] miss_count_o,
    output logic [31:0] hit_rate_o
);

    logic [31:0] hit_cnt_q;
    logic [31:0] miss_cnt_q;
    logic [31:0] total;

    // Counters step at the acceptance edge
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            hit_cnt_q  <= '0;
            miss_cnt_q <= '0;
        end else if (access_i && access_hit_i) begin
            hit_cnt_q <= hit_cnt_q + 32'd1;
        end else if (access_i) begin
            miss_cnt_q <= miss_cnt_q + 32'd1;
        end
    end

    assign hit_count_o  = hit_cnt_q;
    assign miss_count_o = miss_cnt_q;

    // Integer percentage, truncated
    assign total      = hit_cnt_q + miss_cnt_q;
    assign hit_rate_o = (total == '0) ? '0 : (hit_cnt_q * 32'd100) / total;

    // The hit flag only qualifies an access
    a_hit_with_access : assert property (@(posedge clk_i) disable iff (!rst_ni)
        access_hit_i |-> access_i);

endmodule

// File: src/icache_pkg.sv
`include "icache_params.svh"

package icache_pkg;

    // =================================================================
    // Address and data types
    // =================================================================

    // Byte address as seen by the fetch unit
    typedef logic [`ICACHE_ADDR_W-1:0] addr_t;

    // One instruction word
    typedef logic [31:0] word_t;

    // Word position inside a line
    typedef logic [$clog2(`ICACHE_LINE_WORDS)-1:0] word_sel_t;

    // Set index
    typedef logic [$clog2(`ICACHE_SETS)-1:0] index_t;

    // Tag is what remains above index, word select and the byte offset
    typedef logic [`ICACHE_ADDR_W-$bits(index_t)-$bits(word_sel_t)-2-1:0] tag_t;

    // Address layout from the top is tag, index, word select, 2-bit byte offset

endpackage

// File: src/icache_refill_ctrl.sv
`timescale 1ns/10ps
`include "icache_params.svh"

module icache_refill_ctrl (
    input  logic              clk_i,
    input  logic              rst_ni,

    // CPU request and response
    input  logic              cpu_req_valid_i,
    input  icache_pkg::addr_t cpu_req_addr_i,
    output logic              cpu_req_ready_o,
    output logic              cpu_rsp_valid_o,
    output icache_pkg::word_t cpu_rsp_data_o,
    output logic              cpu_rsp_hit_o,

    // Memory side
    output logic              mem_req_valid_o,
    output icache_pkg::addr_t mem_req_addr_o,
    input  logic              mem_req_ready_i,
    input  logic              mem_rsp_valid_i,
    input  icache_pkg::word_t mem_rsp_data_i,

    // Flush control
    input  logic              flush_i,
    output logic              flush_done_o,

    // Array lookup results and controls
    input  logic              hit_i,
    input  logic              hit_way_i,
    input  logic              victim_way_i,
    input  icache_pkg::word_t hit_data_i,
    output icache_pkg::addr_t lookup_addr_o,
    output logic              touch_o,
    output logic              array_flush_o,
    icache_fill_if.ctrl       fill,

    // Access pulse for the counters
    output logic              access_o,
    output logic              access_hit_o
);

    typedef enum logic [1:0] {
        st_idle,
        st_req,
        st_wait_rsp,
        st_flush
    } state_e;

    state_e state_q;

    // Miss context
    icache_pkg::tag_t      miss_tag_q;
    icache_pkg::index_t    miss_index_q;
    icache_pkg::word_sel_t miss_wsel_q;
    logic                  victim_q;
    icache_pkg::word_sel_t word_cnt_q;
    icache_pkg::word_t     req_word_q;

    // Response register
    logic                  rsp_valid_q;
    logic                  rsp_hit_q;
    icache_pkg::word_t     rsp_data_q;

    logic accept;
    logic rsp_beat;
    logic last_word;

    // =================================================================
    // Handshakes and array control
    // =================================================================

    // Flush wins over a request arriving in the same idle cycle
    assign cpu_req_ready_o = (state_q == st_idle) && !flush_i;
    assign accept          = cpu_req_valid_i && cpu_req_ready_o;
    assign array_flush_o   = (state_q == st_idle) && flush_i;
    assign flush_done_o    = (state_q == st_flush);

    assign lookup_addr_o = cpu_req_addr_i;
    // An accepted hit marks its way most recent in the array
    assign touch_o       = accept && hit_i;
    assign access_o      = accept;
    assign access_hit_o  = accept && hit_i;

    // Line base plus the current word with byte offset zero
    assign mem_req_valid_o = (state_q == st_req);
    assign mem_req_addr_o  = {miss_tag_q, miss_index_q, word_cnt_q, 2'b00};

    assign rsp_beat  = (state_q == st_wait_rsp) && mem_rsp_valid_i;
    assign last_word = (word_cnt_q == icache_pkg::word_sel_t'(`ICACHE_LINE_WORDS - 1));

    // Every response beat is written straight into the victim way
    assign fill.word_we  = rsp_beat;
    assign fill.way      = victim_q;
    assign fill.index    = miss_index_q;
    assign fill.word_sel = word_cnt_q;
    assign fill.data     = mem_rsp_data_i;
    assign fill.commit   = rsp_beat && last_word;
    assign fill.tag      = miss_tag_q;

    assign cpu_rsp_valid_o = rsp_valid_q;
    assign cpu_rsp_hit_o   = rsp_hit_q;
    assign cpu_rsp_data_o  = rsp_data_q;

    // =================================================================
    // Miss state machine
    // =================================================================

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= st_idle;
            word_cnt_q  <= '0;
            rsp_valid_q <= 1'b0;
            rsp_hit_q   <= 1'b0;
        end else begin
            rsp_valid_q <= 1'b0;
            case (state_q)
                st_idle: begin
                    if (flush_i) begin
                        state_q <= st_flush;
                    end else if (accept && hit_i) begin
                        rsp_valid_q <= 1'b1;
                        rsp_hit_q   <= 1'b1;
                    end else if (accept) begin
                        state_q    <= st_req;
                        word_cnt_q <= '0;
                    end
                end
                st_req: begin
                    if (mem_req_ready_i) begin
                        state_q <= st_wait_rsp;
                    end
                end
                st_wait_rsp: begin
                    if (mem_rsp_valid_i && last_word) begin
                        // Line commits at this edge and is answered as a miss
                        state_q     <= st_idle;
                        rsp_valid_q <= 1'b1;
                        rsp_hit_q   <= 1'b0;
                    end else if (mem_rsp_valid_i) begin
                        state_q    <= st_req;
                        word_cnt_q <= word_cnt_q + 1'b1;
                    end
                end
                default: begin
                    state_q <= st_idle;
                end
            endcase
        end
    end

    // Miss context and response payload
    always_ff @(posedge clk_i) begin
        if (accept) begin
            {miss_tag_q, miss_index_q, miss_wsel_q} <= cpu_req_addr_i[`ICACHE_ADDR_W-1:2];
            victim_q   <= victim_way_i;
            rsp_data_q <= hit_data_i;
        end
        // Keep the requested word as it streams past
        if (rsp_beat && (word_cnt_q == miss_wsel_q)) begin
            req_word_q <= mem_rsp_data_i;
        end
        if (rsp_beat && last_word) begin
            rsp_data_q <= (word_cnt_q == miss_wsel_q) ? mem_rsp_data_i : req_word_q;
        end
    end

    // Address must not move while memory stalls the request
    a_mem_req_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_addr_o));

    // The miss answer only comes after the whole line is back
    a_no_rsp_during_refill : assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_valid_o |-> !cpu_rsp_valid_o);

endmodule

// File: src/icache_top.sv
`timescale 1ns/10ps

module icache_top (
    input  logic              clk_i,
    input  logic              rst_ni,

    // CPU request
    input  logic              cpu_req_valid_i,
    input  icache_pkg::addr_t cpu_req_addr_i,
    output logic              cpu_req_ready_o,

    // CPU response
    output logic              cpu_rsp_valid_o,
    output icache_pkg::word_t cpu_rsp_data_o,
    output logic              cpu_rsp_hit_o,

    // Memory
    output logic              mem_req_valid_o,
    output icache_pkg::addr_t mem_req_addr_o,
    input  logic              mem_req_ready_i,
    input  logic              mem_rsp_valid_i,
    input  icache_pkg::word_t mem_rsp_data_i,

    // Control and performance
    input  logic              flush_i,
    output logic              flush_done_o,
    output logic [31:0]       perf_hit_count_o,
    output logic [31:0]       perf_miss_count_o,
    output logic [31:0]       perf_hit_rate_o
);

    // =================================================================
    // Internal connections
    // =================================================================

    icache_pkg::addr_t lookup_addr;
    icache_pkg::word_t hit_data;
    logic              touch;
    logic              array_flush;
    logic              hit;
    logic              hit_way;
    logic              victim_way;
    logic              access;
    logic              access_hit;

    // Refill writes from controller to array
    icache_fill_if fill_if ();

    icache_array icache_array_inst (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .lookup_addr_i(lookup_addr),
        .touch_i      (touch),
        .flush_i      (array_flush),
        .fill         (fill_if.array),
        .hit_o        (hit),
        .hit_way_o    (hit_way),
        .victim_way_o (victim_way),
        .hit_data_o   (hit_data)
    );

    icache_refill_ctrl icache_refill_ctrl_inst (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .cpu_req_valid_i(cpu_req_valid_i),
        .cpu_req_addr_i (cpu_req_addr_i),
        .cpu_req_ready_o(cpu_req_ready_o),
        .cpu_rsp_valid_o(cpu_rsp_valid_o),
        .cpu_rsp_data_o (cpu_rsp_data_o),
        .cpu_rsp_hit_o  (cpu_rsp_hit_o),
        .mem_req_valid_o(mem_req_valid_o),
        .mem_req_addr_o (mem_req_addr_o),
        .mem_req_ready_i(mem_req_ready_i),
        .mem_rsp_valid_i(mem_rsp_valid_i),
        .mem_rsp_data_i (mem_rsp_data_i),
        .flush_i        (flush_i),
        .flush_done_o   (flush_done_o),
        .hit_i          (hit),
        .hit_way_i      (hit_way),
        .victim_way_i   (victim_way),
        .hit_data_i     (hit_data),
        .lookup_addr_o  (lookup_addr),
        .touch_o        (touch),
        .array_flush_o  (array_flush),
        .fill           (fill_if.ctrl),
        .access_o       (access),
        .access_hit_o   (access_hit)
    );

    icache_perf icache_perf_inst (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .access_i    (access),
        .access_hit_i(access_hit),
        .hit_count_o (perf_hit_count_o),
        .miss_count_o(perf_miss_count_o),
        .hit_rate_o  (perf_hit_rate_o)
    );

endmodule

// File: verification/icache_tb.sv
`timescale 1ns/10ps

module icache_tb;

    localparam int ACCEPT_LIMIT = 300;
    localparam int DRAIN_LIMIT  = 300;
    localparam int FLUSH_LIMIT  = 8;

    logic              clk_i;
    logic              rst_ni;
    logic              cpu_req_valid_i;
    icache_pkg::addr_t cpu_req_addr_i;
    logic              cpu_req_ready_o;
    logic              cpu_rsp_valid_o;
    icache_pkg::word_t cpu_rsp_data_o;
    logic              cpu_rsp_hit_o;
    logic              mem_req_valid_o;
    icache_pkg::addr_t mem_req_addr_o;
    logic              mem_req_ready_i;
    logic              mem_rsp_valid_i;
    icache_pkg::word_t mem_rsp_data_i;
    logic              flush_i;
    logic              flush_done_o;
    logic [31:0]       perf_hit_count_o;
    logic [31:0]       perf_miss_count_o;
    logic [31:0]       perf_hit_rate_o;

    // Outstanding reads in acceptance order
    icache_pkg::addr_t exp_addr_q [$];
    icache_pkg::word_t exp_data_q [$];
    logic              exp_hit_q  [$];

    icache_pkg::addr_t last_req_addr;
    int                errors;
    int                tests_run;
    int                tests_failed;
    logic              timeout_hit;

    icache_top icache_top_inst (.*);

    // ===================================================================
    // Clock
    // ===================================================================

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // ===================================================================
    // Check helpers
    // ===================================================================

    task automatic compare_value(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
        assert (act_v === exp_v) else begin
            $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp_v, act_v);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout while waiting for %s at %0t", what, $time);
        timeout_hit = 1'b1;
    endtask

    // Present one read and hold it until the cache takes it
    task automatic issue_read(input icache_pkg::addr_t addr, input icache_pkg::word_t data,
                              input logic hit);
        int cycles;
        cycles = 0;
        @(negedge clk_i);
        cpu_req_valid_i = 1'b1;
        cpu_req_addr_i  = addr;
        #1;
        while (!cpu_req_ready_o && cycles < ACCEPT_LIMIT) begin
            @(negedge clk_i);
            #1;
            cycles++;
        end
        if (!cpu_req_ready_o) begin
            cpu_req_valid_i = 1'b0;
            report_timeout("request acceptance");
        end else begin
            // Taken at the coming rising edge
            last_req_addr = addr;
            exp_addr_q.push_back(addr);
            exp_data_q.push_back(data);
            exp_hit_q.push_back(hit);
        end
    endtask

    // Stop requesting and let every outstanding read answer
    task automatic drain_responses();
        int cycles;
        cycles = 0;
        @(negedge clk_i);
        cpu_req_valid_i = 1'b0;
        #1;
        while (exp_data_q.size() != 0 && cycles < DRAIN_LIMIT) begin
            @(negedge clk_i);
            #1;
            cycles++;
        end
        if (exp_data_q.size() != 0) begin
            report_timeout("outstanding read responses");
        end
    endtask

    task automatic run_flush();
        int cycles;
        int err_before;
        cycles     = 0;
        err_before = errors;
        @(negedge clk_i);
        cpu_req_valid_i = 1'b0;
        flush_i         = 1'b1;
        #1;
        // Flush has priority and no request is taken in this cycle
        compare_value("cpu_req_ready_o", 32'd0, cpu_req_ready_o);
        @(negedge clk_i);
        flush_i = 1'b0;
        #1;
        while (!flush_done_o && cycles < FLUSH_LIMIT) begin
            @(negedge clk_i);
            #1;
            cycles++;
        end
        if (!flush_done_o) begin
            report_timeout("flush_done_o");
        end else begin
            @(negedge clk_i);
            #1;
            // Done is a single-cycle pulse
            compare_value("flush_done_o", 32'd0, flush_done_o);
            compare_value("cpu_req_ready_o", 32'd1, cpu_req_ready_o);
            tests_run++;
            if (errors != err_before) tests_failed++;
            $display("Flush : %s", (errors == err_before) ? "pass" : "fail");
        end
    endtask

    task automatic check_counters(input int exp_hits, input int exp_misses, input int exp_rate);
        int err_before;
        err_before = errors;
        @(negedge clk_i);
        #1;
        compare_value("perf_hit_count_o", exp_hits, perf_hit_count_o);
        compare_value("perf_miss_count_o", exp_misses, perf_miss_count_o);
        compare_value("perf_hit_rate_o", exp_rate, perf_hit_rate_o);
        tests_run++;
        if (errors != err_before) tests_failed++;
        $display("Counters hits %0d misses %0d rate %0d : %s", exp_hits, exp_misses,
                 exp_rate, (errors == err_before) ? "pass" : "fail");
    endtask

    task automatic check_reset_state();
        int err_before;
        err_before = errors;
        #1;
        compare_value("cpu_req_ready_o", 32'd1, cpu_req_ready_o);
        compare_value("cpu_rsp_valid_o", 32'd0, cpu_rsp_valid_o);
        compare_value("mem_req_valid_o", 32'd0, mem_req_valid_o);
        compare_value("flush_done_o", 32'd0, flush_done_o);
        compare_value("perf_hit_count_o", 32'd0, perf_hit_count_o);
        compare_value("perf_miss_count_o", 32'd0, perf_miss_count_o);
        compare_value("perf_hit_rate_o", 32'd0, perf_hit_rate_o);
        tests_run++;
        if (errors != err_before) tests_failed++;
        $display("Reset state : %s", (errors == err_before) ? "pass" : "fail");
    endtask

    // ===================================================================
    // Memory model with random stalls
    // ===================================================================

    initial begin : memory_model
        int                refill_cnt;
        int                mem_delay;
        int                seed_dummy;
        logic              stall_pending;
        icache_pkg::addr_t stall_addr;
        icache_pkg::addr_t mem_addr;
        icache_pkg::addr_t exp_mem_addr;
        seed_dummy      = $urandom(32'h9e83);
        refill_cnt      = 0;
        stall_pending   = 1'b0;
        mem_req_ready_i = 1'b0;
        mem_rsp_valid_i = 1'b0;
        mem_rsp_data_i  = '0;
        forever begin
            @(negedge clk_i);
            mem_rsp_valid_i = 1'b0;
            if (rst_ni && mem_req_valid_o) begin
                // A stalled request keeps its address
                if (stall_pending) begin
                    compare_value("mem_req_addr_o", stall_addr, mem_req_addr_o);
                end
                if ($urandom_range(3, 0) != 0) begin
                    mem_req_ready_i = 1'b1;
                    mem_addr        = mem_req_addr_o;
                    stall_pending   = 1'b0;
                    // Words come from the missed line base in order 0 to 3
                    exp_mem_addr = {last_req_addr[31:4], 4'b0000} + 32'(refill_cnt * 4);
                    compare_value("mem_req_addr_o", exp_mem_addr, mem_addr);
                    refill_cnt = (refill_cnt + 1) % 4;
                    @(negedge clk_i);
                    mem_req_ready_i = 1'b0;
                    mem_delay       = $urandom_range(3, 0);
                    repeat (mem_delay) @(negedge clk_i);
                    mem_rsp_data_i  = mem_addr ^ 32'hA5A5_5A5A;
                    mem_rsp_valid_i = 1'b1;
                end else begin
                    mem_req_ready_i = 1'b0;
                    stall_pending   = 1'b1;
                    stall_addr      = mem_req_addr_o;
                end
            end else if (rst_ni) begin
                // A stalled request must stay up until memory takes it
                assert (!stall_pending) else begin
                    $display("Memory request withdrawn before ready at %0t", $time);
                    errors++;
                end
                stall_pending = 1'b0;
            end
        end
    end

    // ===================================================================
    // Response checker
    // ===================================================================

    initial begin : response_monitor
        int                err_before;
        icache_pkg::addr_t rsp_addr;
        icache_pkg::word_t rsp_data;
        logic              rsp_hit;
        forever begin
            @(negedge clk_i);
            if (rst_ni && cpu_rsp_valid_o) begin
                assert (exp_data_q.size() != 0) else begin
                    $display("CPU response at %0t with no read outstanding", $time);
                    errors++;
                end
                if (exp_data_q.size() != 0) begin
                    err_before = errors;
                    rsp_addr   = exp_addr_q.pop_front();
                    rsp_data   = exp_data_q.pop_front();
                    rsp_hit    = exp_hit_q.pop_front();
                    compare_value("cpu_rsp_data_o", rsp_data, cpu_rsp_data_o);
                    compare_value("cpu_rsp_hit_o", rsp_hit, cpu_rsp_hit_o);
                    tests_run++;
                    if (errors != err_before) tests_failed++;
                    $display("Read %h %s : %s", rsp_addr, rsp_hit ? "hit " : "miss",
                             (errors == err_before) ? "pass" : "fail");
                end
            end
        end
    end

    // ===================================================================
    // Main sequence from the test data file
    // ===================================================================

    initial begin : main_sequence
        int                fd;
        int                n;
        byte               op;
        string             line;
        icache_pkg::addr_t rd_addr;
        icache_pkg::word_t rd_data;
        logic [31:0]       rd_hit;
        int                exp_hits;
        int                exp_misses;
        int                exp_rate;
        errors          = 0;
        tests_run       = 0;
        tests_failed    = 0;
        timeout_hit     = 1'b0;
        last_req_addr   = '0;
        rst_ni          = 1'b0;
        cpu_req_valid_i = 1'b0;
        cpu_req_addr_i  = '0;
        flush_i         = 1'b0;
        repeat (8) @(negedge clk_i);
        rst_ni = 1'b1;
        check_reset_state();

        fd = $fopen("verification/icache_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file");
            errors++;
        end else begin
            while (!timeout_hit && $fgets(line, fd) != 0) begin
                // Skip blank and comment lines
                if (line.len() > 1 && line.getc(0) != "#") begin
                    op = line.getc(0);
                    case (op)
                        "R": begin
                            n = $sscanf(line, "R %h %h %h", rd_addr, rd_data, rd_hit);
                            if (n != 3) begin
                                $display("Malformed read line: %s", line);
                                errors++;
                            end else begin
                                issue_read(rd_addr, rd_data, rd_hit[0]);
                            end
                        end
                        "F": begin
                            drain_responses();
                            if (!timeout_hit) run_flush();
                        end
                        "C": begin
                            n = $sscanf(line, "C %d %d %d", exp_hits, exp_misses, exp_rate);
                            drain_responses();
                            if (n != 3) begin
                                $display("Malformed counter line: %s", line);
                                errors++;
                            end else if (!timeout_hit) begin
                                check_counters(exp_hits, exp_misses, exp_rate);
                            end
                        end
                        default: begin
                            $display("Unknown test data line: %s", line);
                            errors++;
                        end
                    endcase
                end
            end
            $fclose(fd);
            if (!timeout_hit) drain_responses();
        end

        $display("Tests run %0d, tests failed %0d, check errors %0d", tests_run,
                 tests_failed, errors);
        if (errors == 0 && tests_failed == 0 && !timeout_hit) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: verification/icache_testdata.txt
# R <addr hex> <expected word hex> <expected hit>, F flushes the cache
# C <expected hits> <expected misses> <expected hit rate percent>, all decimal
R 00000000 A5A55A5A 0
R 00000004 A5A55A5E 1
R 00000008 A5A55A52 1
R 0000000C A5A55A56 1
C 3 1 75
R 00000084 A5A55ADE 0
R 00000000 A5A55A5A 1
R 00000104 A5A55B5E 0
R 00000008 A5A55A52 1
R 00000080 A5A55ADA 0
R 00000004 A5A55A5E 1
C 6 4 60
R 00000010 A5A55A4A 0
R 0000001C A5A55A46 1
F
R 00000000 A5A55A5A 0
R 00000080 A5A55ADA 0
R 00000010 A5A55A4A 0
R 00000088 A5A55AD2 1
C 8 8 50
R 12345670 B7910C2A 0
R 12345674 B7910C2E 1
R 1234567C B7910C26 1
C 10 9 52
